/* Makefile */
# Verilator build for the AES key expansion testbench

VERILATOR ?= verilator
TOP       ?= tb_aes_key_expand
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/aes_ks_consts.svh */
////////////////////
// AES key schedule constants
// Word geometry, Rcon start values and round counts
////////////////////

`ifndef AES_KS_CONSTS_SVH
`define AES_KS_CONSTS_SVH

// Key state geometry
`define KS_WORD_W    32
`define KS_NUM_WORDS 8

// Rcon start values
// Forward always starts at x^0
`define KS_RCON_FWD_INIT 8'h01
// Inverse starts at the last Rcon used by the forward schedule
`define KS_RCON_INV_128  8'h36
`define KS_RCON_INV_256  8'h40

// Number of rounds per key length
`define KS_ROUNDS_128 10
`define KS_ROUNDS_256 14

`endif

/* common/aes_ks_pkg.sv */
////////////////////
// AES key schedule package
// Shared types and GF(2^8) helpers for Rcon stepping
////////////////////

package aes_ks_pkg;

  `include "aes_ks_consts.svh"

  // Direction of the key schedule
  typedef enum logic {
    ciph_fwd = 1'b0,
    ciph_inv = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    aes_128 = 1'b0,
    aes_256 = 1'b1
  } key_len_e;

  // One schedule word, seen whole by the XOR chain or bytewise by the S-box lanes
  typedef union packed {
    logic [`KS_WORD_W-1:0] word;
    logic [3:0][7:0]       bytes;
  } key_word_u;

  // Full key state, word 0 in the LSBs
  typedef logic [`KS_NUM_WORDS-1:0][`KS_WORD_W-1:0] key_state_t;

  ////////////////////
  // GF(2^8) helpers
  ////////////////////

  // Multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul2(logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // Divide by x, the exact inverse of gf_mul2
  function automatic logic [7:0] gf_div2(logic [7:0] a);
    return {1'b0, a[7:1]} ^ (a[0] ? 8'h8d : 8'h00);
  endfunction

  // Last round index for a key length
  function automatic int unsigned num_rounds(key_len_e len);
    return (len == aes_256) ? `KS_ROUNDS_256 : `KS_ROUNDS_128;
  endfunction

endpackage

/* flist.f */
+incdir+common
+incdir+verification
common/aes_ks_pkg.sv
source/aes_sbox.sv
key_expand/aes_rcon_gen.sv
key_expand/aes_sched_word.sv
key_expand/aes_key_words.sv
key_expand/aes_key_expand.sv
verification/tb_aes_key_expand.sv

/* key_expand/aes_key_expand.sv */
////////////////////
// AES key expansion top
// Computes the next round key state for AES-128/256
// in both directions, with Rcon held in a register
////////////////////

`timescale 1ns/10ps

module aes_key_expand (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  aes_ks_pkg::ciph_op_e   op_i,
  input  aes_ks_pkg::key_len_e   key_len_i,
  input  logic [3:0]             round_i,
  input  logic                   clear_i,
  input  logic                   step_i,
  input  aes_ks_pkg::key_state_t key_i,
  output aes_ks_pkg::key_state_t key_o
);

  // Rcon value and its use flag for this round
  logic [7:0]            rcon;
  logic                  rcon_use;
  // Word coming out of RotWord/SubWord/Rcon
  aes_ks_pkg::key_word_u irregular;

  // Rcon register and round decision
  aes_rcon_gen u_rcon_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .op_i       (op_i),
    .key_len_i  (key_len_i),
    .round_i    (round_i),
    .clear_i    (clear_i),
    .step_i     (step_i),
    .rcon_o     (rcon),
    .rcon_use_o (rcon_use)
  );

  // Irregular word, the only path through the S-boxes
  aes_sched_word u_sched_word (
    .op_i        (op_i),
    .key_len_i   (key_len_i),
    .key_i       (key_i),
    .rcon_i      (rcon),
    .rcon_use_i  (rcon_use),
    .irregular_o (irregular)
  );

  // XOR chain and word shifting
  aes_key_words u_key_words (
    .op_i        (op_i),
    .key_len_i   (key_len_i),
    .round_i     (round_i),
    .key_i       (key_i),
    .irregular_i (irregular),
    .key_o       (key_o)
  );

endmodule

/* key_expand/aes_key_words.sv */
////////////////////
// AES key words
// XOR chain and word shifting that build
// the next key state from the irregular word
////////////////////

`timescale 1ns/10ps

module aes_key_words (
  input  aes_ks_pkg::ciph_op_e   op_i,
  input  aes_ks_pkg::key_len_e   key_len_i,
  input  logic [3:0]             round_i,
  input  aes_ks_pkg::key_state_t key_i,
  input  aes_ks_pkg::key_word_u  irregular_i,
  output aes_ks_pkg::key_state_t key_o
);

  aes_ks_pkg::key_state_t next_key;

  always_comb begin : next_key_calc
    // Halves swapped, also the AES-256 round 0 result
    next_key = {key_i[3:0], key_i[7:4]};

    unique case (key_len_i)

      ////////////////////
      // AES-128
      ////////////////////
      aes_ks_pkg::aes_128: begin
        // Upper words unused, they keep the old lower words
        next_key[7:4] = key_i[3:0];
        next_key[0]   = irregular_i.word ^ key_i[0];
        for (int i = 1; i < 4; i++) begin
          if (op_i == aes_ks_pkg::ciph_fwd) begin
            // Running chain from the new word 0
            next_key[i] = next_key[i-1] ^ key_i[i];
          end else begin
            // Neighbour XOR undoes the chain
            next_key[i] = key_i[i-1] ^ key_i[i];
          end
        end
      end

      ////////////////////
      // AES-256
      ////////////////////
      aes_ks_pkg::aes_256: begin
        if (round_i != 4'd0) begin
          if (op_i == aes_ks_pkg::ciph_fwd) begin
            // Old upper half moves down
            next_key[3:0] = key_i[7:4];
            // New upper half
            next_key[4]   = irregular_i.word ^ key_i[0];
            for (int i = 1; i < 4; i++) begin
              next_key[i+4] = next_key[i+3] ^ key_i[i];
            end
          end else begin
            // Old lower half moves up
            next_key[7:4] = key_i[3:0];
            // Recovered lower half
            next_key[0]   = irregular_i.word ^ key_i[4];
            for (int i = 0; i < 3; i++) begin
              next_key[i+1] = key_i[i+4] ^ key_i[i+5];
            end
          end
        end
      end
    endcase
  end

  assign key_o = next_key;

endmodule

/* key_expand/aes_rcon_gen.sv */
////////////////////
// AES Rcon generator
// Holds Rcon, steps it by x or 1/x per round
// and flags rounds that use it
////////////////////

`timescale 1ns/10ps

`include "aes_ks_consts.svh"

module aes_rcon_gen (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  aes_ks_pkg::ciph_op_e op_i,
  input  aes_ks_pkg::key_len_e key_len_i,
  input  logic [3:0]           round_i,
  input  logic                 clear_i,
  input  logic                 step_i,
  output logic [7:0]           rcon_o,
  output logic                 rcon_use_o
);

  logic [7:0] rcon_d;
  logic [7:0] rcon_q;
  logic       rcon_we;

  // AES-256 even rounds skip RotWord and Rcon
  assign rcon_use_o = ~((key_len_i == aes_ks_pkg::aes_256) & ~round_i[0]);

  // Next Rcon value
  always_comb begin : rcon_next
    if (clear_i) begin
      // Start value depends on direction and key length
      if (op_i == aes_ks_pkg::ciph_fwd) begin
        rcon_d = `KS_RCON_FWD_INIT;
      end else if (key_len_i == aes_ks_pkg::aes_128) begin
        rcon_d = `KS_RCON_INV_128;
      end else begin
        rcon_d = `KS_RCON_INV_256;
      end
    end else if (op_i == aes_ks_pkg::ciph_fwd) begin
      rcon_d = aes_ks_pkg::gf_mul2(rcon_q);
    end else begin
      rcon_d = aes_ks_pkg::gf_div2(rcon_q);
    end
  end

  // Clear has priority, step only moves Rcon on rounds that consume it
  assign rcon_we = clear_i | (step_i & rcon_use_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin : rcon_reg
    if (!rst_ni) begin
      rcon_q <= `KS_RCON_FWD_INIT;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

endmodule

/* key_expand/aes_sched_word.sv */
////////////////////
// AES schedule word
// RotWord, SubWord and Rcon addition on the
// one irregular word of each round
////////////////////

`timescale 1ns/10ps

module aes_sched_word (
  input  aes_ks_pkg::ciph_op_e   op_i,
  input  aes_ks_pkg::key_len_e   key_len_i,
  input  aes_ks_pkg::key_state_t key_i,
  input  logic [7:0]             rcon_i,
  input  logic                   rcon_use_i,
  output aes_ks_pkg::key_word_u  irregular_o
);

  aes_ks_pkg::key_word_u src_word;
  aes_ks_pkg::key_word_u rot_word;
  aes_ks_pkg::key_word_u sub_in;
  aes_ks_pkg::key_word_u sub_out;

  // Source word selection
  always_comb begin : src_mux
    if (key_len_i == aes_ks_pkg::aes_128) begin
      // Inverse rebuilds the previous word 3 from words 3 and 2
      src_word.word = (op_i == aes_ks_pkg::ciph_fwd) ? key_i[3] : key_i[3] ^ key_i[2];
    end else begin
      src_word.word = (op_i == aes_ks_pkg::ciph_fwd) ? key_i[7] : key_i[3];
    end
  end

  // RotWord, byte 1 moves down to byte 0
  assign rot_word.word = {src_word.bytes[0], src_word.bytes[3:1]};

  // Rotation only on rounds that also add Rcon
  assign sub_in = rcon_use_i ? rot_word : src_word;

  // SubWord, one S-box per byte lane
  for (genvar i = 0; i < 4; i++) begin : gen_sbox
    aes_sbox u_sbox (
      .data_i (sub_in.bytes[i]),
      .data_o (sub_out.bytes[i])
    );
  end

  // Rcon goes into byte 0 only
  always_comb begin : rcon_add
    irregular_o = sub_out;
    if (rcon_use_i) begin
      irregular_o.bytes[0] = sub_out.bytes[0] ^ rcon_i;
    end
  end

endmodule

/* source/aes_sbox.sv */
////////////////////
// AES S-box
// Forward SubBytes table, purely combinational
////////////////////

`timescale 1ns/10ps

module aes_sbox (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // Entry n holds S(n)
  localparam logic [7:0] sbox_lut [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Plain table lookup
  assign data_o = sbox_lut[data_i];

endmodule

/* verification/tb_aes_ks_model.svh */
////////////////////
// AES key schedule reference model
// Software S-box, FIPS-197 expansion, LCG and compare tasks
////////////////////

`ifndef TB_AES_KS_MODEL_SVH
`define TB_AES_KS_MODEL_SVH

// Expanded schedule, byte a0 of each word in bits 7:0
logic [31:0] ref_w [60];
logic [31:0] lcg_state = 32'h007c_a55b;
int unsigned error_count = 0;

// Full GF(2^8) product, shift and add
function automatic logic [7:0] gf_mult(logic [7:0] a, logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) p ^= x;
    x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// Inverse as a^254, then the affine map
function automatic logic [7:0] soft_sbox(logic [7:0] a);
  logic [7:0] inv;
  logic [7:0] t;
  logic [7:0] s;
  inv = 8'h01;
  for (int i = 0; i < 254; i++) inv = gf_mult(inv, a);
  t = inv;
  s = inv;
  for (int k = 0; k < 4; k++) begin
    t = {t[6:0], t[7]};
    s ^= t;
  end
  return s ^ 8'h63;
endfunction

function automatic logic [31:0] sub_word(logic [31:0] w);
  logic [31:0] r;
  for (int b = 0; b < 4; b++) r[8*b +: 8] = soft_sbox(w[8*b +: 8]);
  return r;
endfunction

// FIPS words are written a0 first, swap into the DUT byte order
function automatic logic [31:0] bswap(logic [31:0] w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// Plain FIPS-197 key expansion into ref_w
function automatic void expand_key(aes_ks_pkg::key_len_e len, aes_ks_pkg::key_state_t key);
  int nk;
  int total;
  logic [7:0] rc;
  logic [31:0] temp;
  nk = (len == aes_ks_pkg::aes_256) ? 8 : 4;
  total = (nk == 8) ? 60 : 44;
  rc = 8'h01;
  for (int i = 0; i < nk; i++) ref_w[i] = key[i];
  for (int i = nk; i < total; i++) begin
    temp = ref_w[i-1];
    if (i % nk == 0) begin
      // RotWord moves a1 into the a0 position
      temp = sub_word({temp[7:0], temp[31:8]});
      temp[7:0] ^= rc;
      rc = gf_mult(rc, 8'h02);
    end else if (nk == 8 && i % nk == 4) begin
      temp = sub_word(temp);
    end
    ref_w[i] = ref_w[i-nk] ^ temp;
  end
endfunction

// Key state with lower half from ref_w[lo] and upper half from ref_w[hi]
function automatic aes_ks_pkg::key_state_t ref_state(int lo, int hi);
  aes_ks_pkg::key_state_t s;
  for (int i = 0; i < 4; i++) begin
    s[i]   = ref_w[lo+i];
    s[i+4] = ref_w[hi+i];
  end
  return s;
endfunction

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic aes_ks_pkg::key_state_t random_key();
  aes_ks_pkg::key_state_t k;
  for (int i = 0; i < 8; i++) k[i] = lcg_next();
  return k;
endfunction

task automatic check_state(string name, aes_ks_pkg::key_state_t got,
                           aes_ks_pkg::key_state_t exp);
  if (got !== exp) begin
    $display("ERROR %s got %h expected %h", name, got, exp);
    error_count++;
  end
endtask

task automatic check_word(string name, aes_ks_pkg::key_word_u got,
                          aes_ks_pkg::key_word_u exp);
  if (got !== exp) begin
    $display("ERROR %s got %h expected %h", name, got.word, exp.word);
    error_count++;
  end
endtask

`endif

/* verification/tb_aes_key_expand.sv */
////////////////////
// AES key expansion testbench
// Directed runs against the software schedule
////////////////////

`timescale 1ns/10ps

`include "aes_ks_consts.svh"

module tb_aes_key_expand;

  `include "tb_aes_ks_model.svh"

  // Each key run takes at most about 16 cycles
  localparam int NUM_RUNS = 24;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * 16 + 50 + 10;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  aes_ks_pkg::ciph_op_e   op_i;
  aes_ks_pkg::key_len_e   key_len_i;
  logic [3:0]             round_i;
  logic                   clear_i;
  logic                   step_i;
  aes_ks_pkg::key_state_t key_i;
  aes_ks_pkg::key_state_t key_o;

  // Key register owned by the testbench
  aes_ks_pkg::key_state_t key_reg;
  int unsigned            tests_failed = 0;

  aes_key_expand u_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .op_i      (op_i),
    .key_len_i (key_len_i),
    .round_i   (round_i),
    .clear_i   (clear_i),
    .step_i    (step_i),
    .key_i     (key_i),
    .key_o     (key_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////
  // Drive helpers
  ////////////////////

  task automatic restart_rcon(aes_ks_pkg::ciph_op_e op, aes_ks_pkg::key_len_e len);
    @(posedge clk_i);
    #1;
    op_i = op;
    key_len_i = len;
    clear_i = 1'b1;
    step_i = 1'b0;
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
  endtask

  // One round, step committed at the following edge
  task automatic do_round(int r, aes_ks_pkg::key_state_t exp);
    @(posedge clk_i);
    #1;
    round_i = 4'(r);
    key_i = key_reg;
    step_i = 1'b1;
    #1;
    check_state($sformatf("key_o round %0d", r), key_o, exp);
    key_reg = key_o;
  endtask

  task automatic stop_step();
    @(posedge clk_i);
    #1;
    step_i = 1'b0;
  endtask

  task automatic report_test(string name, int unsigned errs_before);
    if (error_count == errs_before) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s failed with %0d errors", name, error_count - errs_before);
      tests_failed++;
    end
  endtask

  ////////////////////
  // Key runs
  ////////////////////

  task automatic run_fwd_128(aes_ks_pkg::key_state_t key, bit use_clear);
    if (use_clear) restart_rcon(aes_ks_pkg::ciph_fwd, aes_ks_pkg::aes_128);
    expand_key(aes_ks_pkg::aes_128, key);
    key_reg = '0;
    key_reg[3:0] = key[3:0];
    for (int r = 1; r <= `KS_ROUNDS_128; r++) do_round(r, ref_state(4*r, 4*r-4));
    stop_step();
  endtask

  task automatic run_inv_128(aes_ks_pkg::key_state_t key);
    expand_key(aes_ks_pkg::aes_128, key);
    restart_rcon(aes_ks_pkg::ciph_inv, aes_ks_pkg::aes_128);
    key_reg = ref_state(40, 36);
    for (int r = `KS_ROUNDS_128; r >= 1; r--) do_round(r, ref_state(4*r-4, 4*r));
    stop_step();
  endtask

  task automatic run_fwd_256(aes_ks_pkg::key_state_t key);
    restart_rcon(aes_ks_pkg::ciph_fwd, aes_ks_pkg::aes_256);
    expand_key(aes_ks_pkg::aes_256, key);
    key_reg = key;
    // Round 0 only swaps halves and is not loaded back
    @(posedge clk_i);
    #1;
    round_i = 4'd0;
    key_i = key_reg;
    #1;
    check_state("key_o round 0", key_o, ref_state(4, 0));
    for (int r = 1; r < `KS_ROUNDS_256; r++) do_round(r, ref_state(4*r, 4*r+4));
    stop_step();
  endtask

  task automatic run_inv_256(aes_ks_pkg::key_state_t key);
    expand_key(aes_ks_pkg::aes_256, key);
    restart_rcon(aes_ks_pkg::ciph_inv, aes_ks_pkg::aes_256);
    key_reg = ref_state(52, 56);
    for (int r = `KS_ROUNDS_256 - 1; r >= 1; r--) do_round(r, ref_state(4*r-4, 4*r));
    stop_step();
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_fwd_128_vector();
    int unsigned errs;
    aes_ks_pkg::key_state_t key;
    aes_ks_pkg::key_word_u got;
    aes_ks_pkg::key_word_u exp;
    logic [31:0] last [4];
    errs = error_count;
    key = '0;
    key[0] = bswap(32'h2b7e1516);
    key[1] = bswap(32'h28aed2a6);
    key[2] = bswap(32'habf71588);
    key[3] = bswap(32'h09cf4f3c);
    last = '{32'hd014f9a8, 32'hc9ee2589, 32'he13f0cc8, 32'hb6630ca6};
    // Rcon still holds its reset value
    run_fwd_128(key, 1'b0);
    for (int i = 0; i < 4; i++) begin
      got.word = key_reg[i];
      exp.word = bswap(last[i]);
      check_word($sformatf("key_o[%0d] round 10", i), got, exp);
    end
    report_test("aes128_fwd_vector", errs);
  endtask

  task automatic test_fwd_128_random();
    int unsigned errs;
    errs = error_count;
    for (int n = 0; n < 8; n++) run_fwd_128(random_key(), 1'b1);
    report_test("aes128_fwd_random", errs);
  endtask

  task automatic test_fwd_256();
    int unsigned errs;
    aes_ks_pkg::key_state_t key;
    aes_ks_pkg::key_word_u got;
    aes_ks_pkg::key_word_u exp;
    logic [31:0] fips [8];
    logic [31:0] last [4];
    errs = error_count;
    fips = '{32'h603deb10, 32'h15ca71be, 32'h2b73aef0, 32'h857d7781,
             32'h1f352c07, 32'h3b6108d7, 32'h2d9810a3, 32'h0914dff4};
    last = '{32'hfe4890d1, 32'he6188d0b, 32'h046df344, 32'h706c631e};
    for (int i = 0; i < 8; i++) key[i] = bswap(fips[i]);
    run_fwd_256(key);
    // Words 56 to 59 of the published schedule
    for (int i = 0; i < 4; i++) begin
      got.word = key_reg[i+4];
      exp.word = bswap(last[i]);
      check_word($sformatf("key_o[%0d] round 13", i + 4), got, exp);
    end
    run_fwd_256(random_key());
    run_fwd_256(random_key());
    report_test("aes256_fwd", errs);
  endtask

  task automatic test_inverse();
    int unsigned errs;
    errs = error_count;
    run_inv_128(random_key());
    run_inv_128(random_key());
    run_inv_256(random_key());
    run_inv_256(random_key());
    report_test("inverse", errs);
  endtask

  task automatic test_step_clear();
    int unsigned errs;
    aes_ks_pkg::key_state_t key;
    aes_ks_pkg::key_state_t held;
    errs = error_count;
    key = random_key();
    restart_rcon(aes_ks_pkg::ciph_fwd, aes_ks_pkg::aes_128);
    expand_key(aes_ks_pkg::aes_128, key);
    key_reg = '0;
    key_reg[3:0] = key[3:0];
    @(posedge clk_i);
    #1;
    round_i = 4'd1;
    key_i = key_reg;
    #1;
    held = key_o;
    check_state("key_o before hold", held, ref_state(4, 0));
    // No step, so Rcon and key_o stay put
    repeat (5) begin
      @(posedge clk_i);
      #2;
      check_state("key_o during hold", key_o, held);
    end
    for (int r = 1; r <= 3; r++) do_round(r, ref_state(4*r, 4*r-4));
    // Clear in the middle of the run
    restart_rcon(aes_ks_pkg::ciph_fwd, aes_ks_pkg::aes_128);
    key_reg = '0;
    key_reg[3:0] = key[3:0];
    do_round(1, ref_state(4, 0));
    stop_step();
    report_test("step_clear", errs);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    rst_ni = 1'b0;
    op_i = aes_ks_pkg::ciph_fwd;
    key_len_i = aes_ks_pkg::aes_128;
    round_i = 4'd0;
    clear_i = 1'b0;
    step_i = 1'b0;
    key_i = '0;
    key_reg = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_fwd_128_vector();
    test_fwd_128_random();
    test_fwd_256();
    test_inverse();
    test_step_clear();

    $display("tests 5, failed %0d, errors %0d", tests_failed, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Ends a stuck run
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
